/* Bender.yml */
package:
  name: fm_timer

sources:
  - files:
      - fm_timer_pkg.sv
      - fm_reg_decode.sv
      - fm_timer_cnt.sv
      - fm_timers.sv
      - fm_status.sv
      - fm_timer_top.sv
  - target: test
    files:
      - fm_timer_props.sv
      - tb_fm_timer.sv

/* fm_reg_decode.sv */
/*
 * Host bus decode for the timer block
 * Address latch, Timer A and B value registers, control register
 * and the one-clock write strobes
 */
`timescale 1ns/10ps

module fm_reg_decode
    import fm_timer_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output tmra_t      value_a,
    output tmrb_t      value_b,
    output logic       load_a,
    output logic       load_b,
    output logic       en_irq_a,
    output logic       en_irq_b,
    output logic       clr_a,
    output logic       clr_b,
    output logic       data_wr
);

    logic       write;
    logic       addr_wr;
    logic       reg_wr;
    logic       ctrl_wr;
    logic [7:0] reg_sel;

    assign write   = !cs_n && !wr_n;
    // Only bank 0 reaches the registers
    assign addr_wr = write && (addr == 2'b00);
    assign reg_wr  = write && (addr == 2'b01);
    assign ctrl_wr = reg_wr && (reg_sel == REG_TMR_CTRL);

    // Address latch
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_sel <= 8'h00;
        end else if (addr_wr) begin
            reg_sel <= din;
        end
    end

    // Timer reload values
    always_ff @(posedge clk) begin
        if (rst) begin
            value_a <= '0;
            value_b <= '0;
        end else if (reg_wr) begin
            case (reg_sel)
                REG_TMRA_HI: value_a[9:2] <= din;
                REG_TMRA_LO: value_a[1:0] <= din[1:0];
                REG_TMRB:    value_b      <= din;
                default:     ;  // Unknown address, dropped
            endcase
        end
    end

    // Load and enable levels from 0x27
    always_ff @(posedge clk) begin
        if (rst) begin
            load_a   <= 1'b0;
            load_b   <= 1'b0;
            en_irq_a <= 1'b0;
            en_irq_b <= 1'b0;
        end else if (ctrl_wr) begin
            load_a   <= din[CTRL_LOAD_A];
            load_b   <= din[CTRL_LOAD_B];
            en_irq_a <= din[CTRL_EN_A];
            en_irq_b <= din[CTRL_EN_B];
        end
    end

    // Strobes land in the clock after the write
    always_ff @(posedge clk) begin
        if (rst) begin
            data_wr <= 1'b0;
            clr_a   <= 1'b0;
            clr_b   <= 1'b0;
        end else begin
            data_wr <= reg_wr;  // Any bank-0 data write, known or not
            clr_a   <= ctrl_wr && din[CTRL_CLR_A];
            clr_b   <= ctrl_wr && din[CTRL_CLR_B];
        end
    end

endmodule

/* fm_status.sv */
/*
 * Result stage
 * Busy countdown after data writes, status byte and interrupt output
 */
`timescale 1ns/10ps

module fm_status
    import fm_timer_pkg::*;
#(
    parameter int BUSY_CYCLES = 32
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       data_wr,
    input  logic       flag_a,
    input  logic       flag_b,
    output logic [7:0] dout,
    output logic       irq_n
);

    localparam int BUSY_W = $clog2(BUSY_CYCLES + 1);

    logic              busy;
    logic [BUSY_W-1:0] busy_cnt;

    // A new write restarts the countdown
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;
            busy_cnt <= BUSY_W'(BUSY_CYCLES);
        end else if (busy && cen) begin
            busy_cnt <= busy_cnt - 1'b1;
            if (busy_cnt == BUSY_W'(1)) begin
                busy <= 1'b0;  // Last cen pulse of the window
            end
        end
    end

    // Unused status bits read as zero
    always_comb begin
        dout              = 8'h00;
        dout[STAT_BUSY]   = busy;
        dout[STAT_FLAG_B] = flag_b;
        dout[STAT_FLAG_A] = flag_a;
    end

    assign irq_n = !(flag_a || flag_b);  // Flags are already registered

endmodule

/* fm_timer_cnt.sv */
/*
 * Reloadable timer up-counter
 * Width follows the payload type, overflow pulses on wrap
 */
`timescale 1ns/10ps

module fm_timer_cnt #(
    parameter type cnt_t = logic [7:0]
) (
    input  logic clk,
    input  logic rst,
    input  logic tick,
    input  logic load,
    input  cnt_t value,
    output logic overflow
);

    cnt_t cnt;
    logic load_l;
    logic load_rise;

    assign load_rise = load && !load_l;

    // Wrap from all-ones on a tick, reload takes priority
    assign overflow = load && !load_rise && tick && (cnt == '1);

    always_ff @(posedge clk) begin
        if (rst) begin
            load_l <= 1'b0;
            cnt    <= '0;
        end else begin
            load_l <= load;
            if (load_rise || overflow) begin
                cnt <= value;
            end else if (load && tick) begin
                cnt <= cnt + 1'b1;
            end
            // Holds while load is low
        end
    end

endmodule

/* fm_timer_pkg.sv */
/*
 * Shared definitions for the FM timer block
 * Register addresses, control and status bit positions, counter types
 */

package fm_timer_pkg;

    // Register map, bank 0
    localparam logic [7:0] REG_TMRA_HI  = 8'h24;  // Timer A bits 9..2
    localparam logic [7:0] REG_TMRA_LO  = 8'h25;  // Timer A bits 1..0
    localparam logic [7:0] REG_TMRB     = 8'h26;
    localparam logic [7:0] REG_TMR_CTRL = 8'h27;

    // Control register 0x27
    localparam int CTRL_LOAD_A = 0;
    localparam int CTRL_LOAD_B = 1;
    localparam int CTRL_EN_A   = 2;
    localparam int CTRL_EN_B   = 3;
    localparam int CTRL_CLR_A  = 4;  // Self-clearing, never stored
    localparam int CTRL_CLR_B  = 5;

    // Status byte on dout
    localparam int STAT_FLAG_A = 0;
    localparam int STAT_FLAG_B = 1;
    localparam int STAT_BUSY   = 7;

    // Timer A ticks per Timer B tick
    localparam int TMRB_PRESCALE = 16;

    typedef logic [9:0] tmra_t;
    typedef logic [7:0] tmrb_t;

endpackage

/* fm_timer_props.sv */
/*
 * Concurrent assertions on the timer top level
 * Interrupt against flags, unused status bits, busy after a data write
 */
`timescale 1ns/10ps

module fm_timer_props
    import fm_timer_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       data_wr,
    input logic [7:0] dout,
    input logic       irq_n
);

    int unsigned assert_errs = 0;  // Failure count, polled by the testbench

    irq_follows_flags: assert property (@(posedge clk) disable iff (rst)
        irq_n == !(dout[STAT_FLAG_A] || dout[STAT_FLAG_B]))
    else begin
        $error("irq_n %0b does not match the flags in dout 0x%0h", irq_n, dout);
        assert_errs++;
    end

    // Bits 6..2 are not used
    unused_bits_zero: assert property (@(posedge clk) disable iff (rst)
        dout[6:2] == 5'b00000)
    else begin
        $error("Unused status bits set, dout 0x%0h", dout);
        assert_errs++;
    end

    busy_after_write: assert property (@(posedge clk) disable iff (rst)
        data_wr |=> dout[STAT_BUSY])
    else begin
        $error("Busy not set in the clock after a data write");
        assert_errs++;
    end

endmodule

bind fm_timer_top fm_timer_props u_props (
    .clk     (clk),
    .rst     (rst),
    .data_wr (data_wr),
    .dout    (dout),
    .irq_n   (irq_n)
);

/* fm_timer_top.sv */
/*
 * Top level of the FM timer block
 * Bus decode, timers and status stage
 */
`timescale 1ns/10ps

module fm_timer_top
    import fm_timer_pkg::*;
#(
    parameter int CEN_DIV     = 6,   // cen pulses per timer tick
    parameter int BUSY_CYCLES = 32   // cen pulses of busy after a write
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output logic [7:0] dout,
    output logic       irq_n
);

    tmra_t value_a;
    tmrb_t value_b;
    logic  load_a;
    logic  load_b;
    logic  en_irq_a;
    logic  en_irq_b;
    logic  clr_a;
    logic  clr_b;
    logic  data_wr;
    logic  flag_a;
    logic  flag_b;

    fm_reg_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .din      (din),
        .addr     (addr),
        .cs_n     (cs_n),
        .wr_n     (wr_n),
        .value_a  (value_a),
        .value_b  (value_b),
        .load_a   (load_a),
        .load_b   (load_b),
        .en_irq_a (en_irq_a),
        .en_irq_b (en_irq_b),
        .clr_a    (clr_a),
        .clr_b    (clr_b),
        .data_wr  (data_wr)
    );

    // Each enable goes to its own timer
    fm_timers #(.CEN_DIV(CEN_DIV)) u_timers (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .value_a  (value_a),
        .value_b  (value_b),
        .load_a   (load_a),
        .load_b   (load_b),
        .en_irq_a (en_irq_a),
        .en_irq_b (en_irq_b),
        .clr_a    (clr_a),
        .clr_b    (clr_b),
        .flag_a   (flag_a),
        .flag_b   (flag_b)
    );

    fm_status #(.BUSY_CYCLES(BUSY_CYCLES)) u_status (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .data_wr  (data_wr),
        .flag_a   (flag_a),
        .flag_b   (flag_b),
        .dout     (dout),
        .irq_n    (irq_n)
    );

endmodule

/* fm_timers.sv */
/*
 * Timer execute stage
 * cen prescaler, Timer A and Timer B counters, B prescaler,
 * sticky overflow flags with enable gating and clear
 */
`timescale 1ns/10ps

module fm_timers
    import fm_timer_pkg::*;
#(
    parameter int CEN_DIV = 6
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  cen,
    input  tmra_t value_a,
    input  tmrb_t value_b,
    input  logic  load_a,
    input  logic  load_b,
    input  logic  en_irq_a,
    input  logic  en_irq_b,
    input  logic  clr_a,
    input  logic  clr_b,
    output logic  flag_a,
    output logic  flag_b
);

    localparam int DIV_W = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;
    localparam int PRE_W = $clog2(TMRB_PRESCALE);

    logic [DIV_W-1:0] div_cnt;
    logic [PRE_W-1:0] pre_b;
    logic             tick_a;
    logic             tick_b;
    logic             ovf_a;
    logic             ovf_b;

    assign tick_a = cen && (div_cnt == DIV_W'(CEN_DIV - 1));
    assign tick_b = tick_a && (pre_b == PRE_W'(TMRB_PRESCALE - 1));

    // Free-running dividers, independent of the load bits
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            pre_b   <= '0;
        end else begin
            if (cen) begin
                div_cnt <= tick_a ? '0 : div_cnt + 1'b1;
            end
            if (tick_a) begin
                pre_b <= tick_b ? '0 : pre_b + 1'b1;
            end
        end
    end

    fm_timer_cnt #(.cnt_t(tmra_t)) u_tmr_a (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick_a),
        .load     (load_a),
        .value    (value_a),
        .overflow (ovf_a)
    );

    fm_timer_cnt #(.cnt_t(tmrb_t)) u_tmr_b (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick_b),
        .load     (load_b),
        .value    (value_b),
        .overflow (ovf_b)
    );

    // Clear beats a simultaneous set
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (clr_a) begin
                flag_a <= 1'b0;
            end else if (ovf_a && en_irq_a) begin
                flag_a <= 1'b1;
            end
            if (clr_b) begin
                flag_b <= 1'b0;
            end else if (ovf_b && en_irq_b) begin
                flag_b <= 1'b1;
            end
        end
    end

endmodule

/* list.f */
fm_timer_pkg.sv
fm_reg_decode.sv
fm_timer_cnt.sv
fm_timers.sv
fm_status.sv
fm_timer_top.sv
fm_timer_props.sv
tb_fm_timer.sv

/* tb_fm_timer.sv */
/*
 * Testbench for the FM timer block
 * Clock, bus write stimulus, period reference, compare task and the tests
 */
`timescale 1ns/10ps

module tb_fm_timer;
    import fm_timer_pkg::*;

    localparam int CEN_DIV     = 6;
    localparam int BUSY_CYCLES = 32;

    logic       clk;
    logic       rst;
    logic       cen;
    logic [7:0] din;
    logic [1:0] addr;
    logic       cs_n;
    logic       wr_n;
    logic [7:0] dout;
    logic       irq_n;

    integer seed;
    int     errors;
    int     tests;
    int     val_a;  // Timer A value as written
    int     val_b;  // Timer B value as written

    fm_timer_top #(
        .CEN_DIV     (CEN_DIV),
        .BUSY_CYCLES (BUSY_CYCLES)
    ) dut (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .din   (din),
        .addr  (addr),
        .cs_n  (cs_n),
        .wr_n  (wr_n),
        .dout  (dout),
        .irq_n (irq_n)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // Expected overflow period in clocks, cen held high
    function automatic int timer_period(input bit is_b, input int v);
        if (is_b) begin
            return (256 - v) * 16 * CEN_DIV;
        end
        return (1024 - v) * CEN_DIV;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // Address write then data write, returns on the clock that takes the data
    task automatic bus_write(input logic bank, input logic [7:0] reg_addr,
                             input logic [7:0] data);
        @(posedge clk);
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        addr <= {bank, 1'b0};
        din  <= reg_addr;
        @(posedge clk);
        addr <= {bank, 1'b1};
        din  <= data;
        @(posedge clk);
        cs_n <= 1'b1;
        wr_n <= 1'b1;
    endtask

    task automatic write_timer_a(input int v);
        logic [9:0] tv;
        tv = 10'(v);
        bus_write(1'b0, REG_TMRA_HI, tv[9:2]);
        bus_write(1'b0, REG_TMRA_LO, {6'b000000, tv[1:0]});
    endtask

    // Clocks until a status bit reaches the level, 0 on timeout
    task automatic wait_status(input int bit_idx, input logic level, input int limit,
                               output int clocks);
        clocks = 0;
        for (int n = 1; n <= limit; n++) begin
            @(negedge clk);  // Outputs settled
            if (dout[bit_idx] === level) begin
                clocks = n;
                break;
            end
        end
    endtask

    task automatic report_test(input string name, input int start_errs);
        tests++;
        if (errors == start_errs) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - start_errs);
        end
    endtask

    task automatic reset_state();
        int start_errs;
        start_errs = errors;
        @(negedge clk);
        check("dout", dout, 8'h00);
        check("irq_n", irq_n, 1'b1);
        report_test("reset state", start_errs);
    endtask

    task automatic busy_flag();
        int start_errs;
        int clocks;
        start_errs = errors;
        bus_write(1'b0, REG_TMRB, 8'h00);
        wait_status(STAT_BUSY, 1'b1, 2, clocks);
        if (clocks == 0) begin
            $display("Busy did not rise after a data write");
            errors++;
        end else begin
            check("busy_delay", clocks, 2);  // Clock after data_wr
        end
        wait_status(STAT_BUSY, 1'b0, BUSY_CYCLES + 2, clocks);
        if (clocks == 0) begin
            $display("Busy stayed set longer than %0d clocks", BUSY_CYCLES + 2);
            errors++;
        end
        check("dout", dout, 8'h00);
        report_test("busy", start_errs);
    endtask

    // Load and enable one timer, measure the flag, then clear and stop it
    task automatic timer_irq(input bit is_b, input int v, input string name);
        int         start_errs;
        int         period;
        int         tick_len;
        int         limit;
        int         clocks;
        int         flag_bit;
        logic [7:0] ctrl;
        logic [7:0] clr;
        start_errs = errors;
        period     = timer_period(is_b, v);
        tick_len   = is_b ? 16 * CEN_DIV : CEN_DIV;  // Start latency is one tick
        limit      = period + CEN_DIV + 2;
        flag_bit   = is_b ? STAT_FLAG_B : STAT_FLAG_A;
        ctrl       = 8'h00;
        clr        = 8'h00;
        ctrl[is_b ? CTRL_LOAD_B : CTRL_LOAD_A] = 1'b1;
        ctrl[is_b ? CTRL_EN_B : CTRL_EN_A]     = 1'b1;
        clr[is_b ? CTRL_CLR_B : CTRL_CLR_A]    = 1'b1;
        bus_write(1'b0, REG_TMR_CTRL, ctrl);
        wait_status(flag_bit, 1'b1, limit, clocks);
        if (clocks == 0) begin
            $display("%s: flag did not rise within %0d clocks", name, limit);
            errors++;
        end else begin
            if (clocks < period - tick_len) begin
                $display("%s: flag rose after %0d clocks, period is %0d", name, clocks, period);
                errors++;
            end
            check("irq_n", irq_n, 1'b0);
        end
        bus_write(1'b0, REG_TMR_CTRL, clr);  // Clear, also drops load and enable
        wait_status(flag_bit, 1'b0, 4, clocks);
        if (clocks == 0) begin
            $display("%s: flag still set after the clear write", name);
            errors++;
        end
        check("irq_n", irq_n, 1'b1);
        report_test(name, start_errs);
    endtask

    task automatic enable_gating();
        int start_errs;
        int v;
        int limit;
        start_errs = errors;
        v     = $random(seed) & 32'h3f;
        limit = 2 * timer_period(1'b0, v) + CEN_DIV;
        write_timer_a(v);
        bus_write(1'b0, REG_TMR_CTRL, 8'h01 << CTRL_LOAD_A);  // Run without enable
        for (int n = 0; n < limit; n++) begin
            @(negedge clk);
            if (dout[STAT_FLAG_A] !== 1'b0 || irq_n !== 1'b1) begin
                $display("Timer A set its flag with the enable clear, after %0d clocks", n);
                errors++;
                break;
            end
        end
        bus_write(1'b0, REG_TMR_CTRL, 8'h00);
        report_test("enable gating", start_errs);
    endtask

    task automatic ignored_writes();
        int         v;
        logic [7:0] junk;
        v = $random(seed) & 32'h3f;
        write_timer_a(v);  // Last valid value
        repeat (4) begin
            bus_write(1'b1, REG_TMRA_HI, $random(seed));  // Bank 1
            bus_write(1'b1, REG_TMRA_LO, $random(seed));
        end
        repeat (4) begin
            junk = $random(seed);
            if (junk inside {[REG_TMRA_HI:REG_TMR_CTRL]}) begin
                junk = junk ^ 8'h80;
            end
            bus_write(1'b0, junk, $random(seed));
        end
        timer_irq(1'b0, v, "ignored writes");
    endtask

    initial begin
        seed   = 32'h6e26_60b6;
        errors = 0;
        tests  = 0;
        rst    = 1'b1;
        cen    = 1'b1;
        din    = 8'h00;
        addr   = 2'b00;
        cs_n   = 1'b1;
        wr_n   = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        reset_state();
        busy_flag();
        val_a = $random(seed) & 32'h3f;
        write_timer_a(val_a);
        timer_irq(1'b0, val_a, "timer A");
        val_b = $random(seed) & 32'h1f;
        bus_write(1'b0, REG_TMRB, 8'(val_b));
        timer_irq(1'b1, val_b, "timer B");
        enable_gating();
        ignored_writes();

        errors += dut.u_props.assert_errs;
        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
